// ==== compile.f ====
+incdir+hw
hw/udma_cfg_pkg.sv
hw/udma_cfg_bus_if.sv
hw/udma_apb_if.sv
hw/udma_chan_regs.sv
hw/udma_evt_ctrl.sv
hw/udma_cfg_top.sv
test/udma_cfg_checker.sv
test/udma_cfg_sva.sv
test/udma_cfg_tb.sv

// ==== hw/udma_apb_if.sv ====
/* APB slave splitter, purely combinational with no wait states added.
   Unmapped selects return PREADY low and PSLVERR is always low */

`timescale 1ns/1ns

`include "udma_cfg_settings.svh"

module udma_apb_if
#(
    parameter int N_PERIPHS = `UDMA_N_CHANNELS + 1
)
(
    input  logic [`UDMA_APB_ADDR_WIDTH-1:0] paddr_i,
    input  udma_cfg_pkg::cfg_data_t         pwdata_i,
    input  logic                            pwrite_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    output udma_cfg_pkg::cfg_data_t         prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,

    udma_cfg_bus_if.ctrl                    periph_o [N_PERIPHS]
);

    import udma_cfg_pkg::*;

    periph_sel_t          periph_sel;
    logic                 access;
    cfg_data_t            rdata_arr [N_PERIPHS];
    logic [N_PERIPHS-1:0] ready_arr;

    // Upper address bits pick the peripheral slot
    assign periph_sel = paddr_i[11:7];
    // Only the access phase reaches a peripheral, setup is hidden
    assign access     = psel_i & penable_i;
    assign pslverr_o  = 1'b0;

    ///////////////////////////////////////////////////////////////////////////
    // Request fan-out
    ///////////////////////////////////////////////////////////////////////////

    // Interface array members need constant indices, so each slot is wired
    // here and its response copied into plain arrays for the mux below
    for (genvar g = 0; g < N_PERIPHS; g++)
    begin : g_periph
        assign periph_o[g].wdata = pwdata_i;
        assign periph_o[g].offs  = paddr_i[6:2];
        assign periph_o[g].rwn   = ~pwrite_i;
        assign periph_o[g].valid = access & (periph_sel == periph_sel_t'(g));
        assign rdata_arr[g]      = periph_o[g].rdata;
        assign ready_arr[g]      = periph_o[g].ready;
    end

    ///////////////////////////////////////////////////////////////////////////
    // Response mux
    ///////////////////////////////////////////////////////////////////////////

    // A select with nothing behind it leaves ready low
    always_comb
    begin
        prdata_o = '0;
        pready_o = 1'b0;
        for (int i = 0; i < N_PERIPHS; i++)
        begin
            if (periph_sel == periph_sel_t'(i))
            begin
                prdata_o = rdata_arr[i];
                pready_o = ready_arr[i];
            end
        end
    end

endmodule

// ==== hw/udma_cfg_bus_if.sv ====
/* Register access path from the APB splitter to one peripheral.
   Peripherals answer without wait states, rdata is combinational from offs */

`timescale 1ns/1ns

interface udma_cfg_bus_if;

    import udma_cfg_pkg::*;

    // Write data, taken straight from PWDATA
    cfg_data_t wdata;
    // Register word offset inside the peripheral
    reg_offs_t offs;
    // High for a read, low for a write
    logic      rwn;
    // Access phase to this peripheral
    logic      valid;

    // Read data for the register addressed by offs
    cfg_data_t rdata;
    // Peripheral accepts the access in this cycle
    logic      ready;

    // Splitter side
    modport ctrl (
        output wdata, offs, rwn, valid,
        input  rdata, ready
    );

    // Peripheral side
    modport periph (
        input  wdata, offs, rwn, valid,
        output rdata, ready
    );

endinterface

// ==== hw/udma_cfg_pkg.sv ====
/* Shared types of the uDMA configuration subsystem.
   Widths come from the settings header */

`include "udma_cfg_settings.svh"

package udma_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register access types
    ////////////////////////////////////////////////////////////////////////////

    // One 32-bit register word as seen on the APB data bus
    typedef logic [31:0] cfg_data_t;

    // Word offset of a register inside one peripheral, PADDR[6:2]
    typedef logic [4:0] reg_offs_t;

    // Peripheral slot number, PADDR[11:7]
    typedef logic [4:0] periph_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // Channel types
    ////////////////////////////////////////////////////////////////////////////

    // Transfer length in bytes
    typedef logic [`UDMA_SIZE_WIDTH-1:0] byte_cnt_t;

    // Byte address in system memory
    typedef logic [31:0] mem_addr_t;

    // A channel either waits for an enable or counts beats
    typedef enum logic {
        CHAN_IDLE,
        CHAN_RUN
    } chan_state_t;

endpackage

// ==== hw/udma_cfg_settings.svh ====
/* Build-time settings for the uDMA configuration subsystem.
   Peripheral select is PADDR[11:7], so UDMA_N_CHANNELS + 1 must not exceed 32 */

`ifndef UDMA_CFG_SETTINGS_SVH
`define UDMA_CFG_SETTINGS_SVH

// Channel count, the event controller takes the slot right after the last channel
`define UDMA_N_CHANNELS     4
`define UDMA_APB_ADDR_WIDTH 12
`define UDMA_SIZE_WIDTH     20

// Channel register word offsets
`define UDMA_REG_SADDR 5'd0
`define UDMA_REG_SIZE  5'd1
`define UDMA_REG_CFG   5'd2
`define UDMA_REG_CURR  5'd3
`define UDMA_REG_LEFT  5'd4

// Event controller register word offsets
`define UDMA_REG_PEND 5'd0
`define UDMA_REG_MASK 5'd1

// Bit positions inside the channel configuration word
`define UDMA_CFG_EN_BIT   0
`define UDMA_CFG_CONT_BIT 1
`define UDMA_CFG_CLR_BIT  5

`endif

// ==== hw/udma_cfg_top.sv ====
/* uDMA configuration subsystem behind a plain APB slave port.
   Channels sit in slots 0 to N-1, the event controller in slot N */

`timescale 1ns/1ns

`include "udma_cfg_settings.svh"

module udma_cfg_top
(
    input  logic                            clk_i,
    input  logic                            rst_i,

    // APB slave port
    input  logic [`UDMA_APB_ADDR_WIDTH-1:0] paddr_i,
    input  udma_cfg_pkg::cfg_data_t         pwdata_i,
    input  logic                            pwrite_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    output udma_cfg_pkg::cfg_data_t         prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,

    // One data beat strobe per channel
    input  logic [`UDMA_N_CHANNELS-1:0]     beat_i,
    output logic                            irq_o
);

    localparam int N_PERIPHS = `UDMA_N_CHANNELS + 1;

    // One access path per peripheral slot
    udma_cfg_bus_if periph_bus [N_PERIPHS] ();

    logic [`UDMA_N_CHANNELS-1:0] chan_done;

    udma_apb_if #(
        .N_PERIPHS (N_PERIPHS)
    ) u_apb_if (
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pwrite_i  (pwrite_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .periph_o  (periph_bus)
    );

    for (genvar g = 0; g < `UDMA_N_CHANNELS; g++)
    begin : g_chan
        udma_chan_regs u_chan_regs (
            .clk_i  (clk_i),
            .rst_i  (rst_i),
            .bus_i  (periph_bus[g]),
            .beat_i (beat_i[g]),
            .done_o (chan_done[g])
        );
    end

    // Last slot
    udma_evt_ctrl u_evt_ctrl (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .bus_i  (periph_bus[`UDMA_N_CHANNELS]),
        .done_i (chan_done),
        .irq_o  (irq_o)
    );

endmodule

// ==== hw/udma_chan_regs.sv ====
/* One uDMA channel, emulated by counting 4-byte beats from outside.
   SIZE is expected to be a multiple of 4; beats on an idle channel are ignored */

`timescale 1ns/1ns

`include "udma_cfg_settings.svh"

module udma_chan_regs
(
    input  logic              clk_i,
    input  logic              rst_i,
    udma_cfg_bus_if.periph    bus_i,
    input  logic              beat_i,
    output logic              done_o
);

    import udma_cfg_pkg::*;

    // Programmed values
    mem_addr_t   saddr;
    byte_cnt_t   size;
    logic        cont;

    // Live transfer state
    chan_state_t state;
    mem_addr_t   curr_addr;
    byte_cnt_t   bytes_left;

    logic        wr_en;
    logic        beat_en;
    logic        last_beat;
    cfg_data_t   rdata;

    // The channel never stalls, so a valid write is always accepted
    assign wr_en     = bus_i.valid & bus_i.ready & ~bus_i.rwn;
    assign beat_en   = beat_i & (state == CHAN_RUN);
    // The beat that moves the last 4 bytes finishes the transfer
    assign last_beat = bytes_left <= byte_cnt_t'(4);

    ////////////////////////////////////////////////////////////////////////////
    // Register and counter update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state      <= CHAN_IDLE;
            cont       <= 1'b0;
            done_o     <= 1'b0;
            saddr      <= '0;
            size       <= '0;
            curr_addr  <= '0;
            bytes_left <= '0;
        end
        else
        begin
            done_o <= 1'b0;

            if (beat_en)
            begin
                if (last_beat)
                begin
                    done_o <= 1'b1;
                    if (cont)
                    begin
                        // Continuous mode restarts from the programmed values
                        curr_addr  <= saddr;
                        bytes_left <= size;
                    end
                    else
                    begin
                        curr_addr  <= curr_addr + mem_addr_t'(4);
                        bytes_left <= '0;
                        state      <= CHAN_IDLE;
                    end
                end
                else
                begin
                    curr_addr  <= curr_addr + mem_addr_t'(4);
                    bytes_left <= bytes_left - byte_cnt_t'(4);
                end
            end

            // A register write in the same cycle overrides the beat update
            if (wr_en)
            begin
                case (bus_i.offs)
                    `UDMA_REG_SADDR: saddr <= bus_i.wdata;
                    `UDMA_REG_SIZE:  size  <= bus_i.wdata[`UDMA_SIZE_WIDTH-1:0];
                    `UDMA_REG_CFG:
                    begin
                        cont <= bus_i.wdata[`UDMA_CFG_CONT_BIT];
                        // Clear has priority over enable
                        if (bus_i.wdata[`UDMA_CFG_CLR_BIT])
                        begin
                            state <= CHAN_IDLE;
                        end
                        else if (bus_i.wdata[`UDMA_CFG_EN_BIT])
                        begin
                            curr_addr  <= saddr;
                            bytes_left <= size;
                            state      <= CHAN_RUN;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////////////////////

    // The enable bit reads back as the run state, so software sees completion
    always_comb
    begin
        rdata = '0;
        case (bus_i.offs)
            `UDMA_REG_SADDR: rdata = saddr;
            `UDMA_REG_SIZE:  rdata = cfg_data_t'(size);
            `UDMA_REG_CFG:
            begin
                rdata[`UDMA_CFG_EN_BIT]   = (state == CHAN_RUN);
                rdata[`UDMA_CFG_CONT_BIT] = cont;
            end
            `UDMA_REG_CURR:  rdata = curr_addr;
            `UDMA_REG_LEFT:  rdata = cfg_data_t'(bytes_left);
            default:         rdata = '0;
        endcase
    end

    assign bus_i.rdata = rdata;
    assign bus_i.ready = 1'b1;

endmodule

// ==== hw/udma_evt_ctrl.sv ====
/* Collects channel done strobes into a pending register with a mask.
   A new event wins over a write-1-to-clear in the same cycle */

`timescale 1ns/1ns

`include "udma_cfg_settings.svh"

module udma_evt_ctrl
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    udma_cfg_bus_if.periph              bus_i,
    input  logic [`UDMA_N_CHANNELS-1:0] done_i,
    output logic                        irq_o
);

    import udma_cfg_pkg::*;

    localparam int N_CH = `UDMA_N_CHANNELS;

    logic [N_CH-1:0] pend;
    logic [N_CH-1:0] mask;
    logic [N_CH-1:0] pend_clr;
    logic            wr_en;
    cfg_data_t       rdata;

    assign wr_en = bus_i.valid & bus_i.ready & ~bus_i.rwn;

    // Bits written as 1 to PEND are the ones to drop
    assign pend_clr = (wr_en && (bus_i.offs == `UDMA_REG_PEND)) ?
                      bus_i.wdata[N_CH-1:0] : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Pending, mask and interrupt
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pend  <= '0;
            mask  <= '0;
            irq_o <= 1'b0;
        end
        else
        begin
            // Setting after clearing lets a fresh done survive the clear
            pend <= (pend & ~pend_clr) | done_i;
            if (wr_en && (bus_i.offs == `UDMA_REG_MASK))
            begin
                mask <= bus_i.wdata[N_CH-1:0];
            end
            // One cycle behind pending and mask
            irq_o <= |(pend & mask);
        end
    end

    // Both registers read back zero-extended
    always_comb
    begin
        case (bus_i.offs)
            `UDMA_REG_PEND: rdata = cfg_data_t'(pend);
            `UDMA_REG_MASK: rdata = cfg_data_t'(mask);
            default:        rdata = '0;
        endcase
    end

    assign bus_i.rdata = rdata;
    assign bus_i.ready = 1'b1;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator, run from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module udma_cfg_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past the first assertion so the testbench can report
./obj_dir/Vudma_cfg_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

// ==== test/udma_cfg_checker.sv ====
/* Compares APB read data and the interrupt level with the expected values
   that the testbench presents with each access phase or irq check */

`timescale 1ns/1ns

`include "udma_cfg_settings.svh"

module udma_cfg_checker
(
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [`UDMA_APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic                            pready_i,
    input  udma_cfg_pkg::cfg_data_t         prdata_i,
    input  logic                            rd_chk_i,
    input  udma_cfg_pkg::cfg_data_t         exp_rdata_i,
    input  logic                            irq_i,
    input  logic                            irq_chk_i,
    input  logic                            exp_irq_i,
    output int                              rd_cnt_o,
    output int                              rd_err_o,
    output int                              irq_err_o
);

    // Inputs move on the falling edge, so the rising edge sees settled values
    always @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rd_cnt_o  <= 0;
            rd_err_o  <= 0;
            irq_err_o <= 0;
        end
        else
        begin
            // Completed read transfer
            if (rd_chk_i && psel_i && penable_i && pready_i && !pwrite_i)
            begin
                rd_cnt_o <= rd_cnt_o + 1;
                if (prdata_i !== exp_rdata_i)
                begin
                    rd_err_o <= rd_err_o + 1;
                    $display("ERR %0t: slot %0d reg %0d read %08h, expected %08h", $time,
                             paddr_i[11:7], paddr_i[6:2], prdata_i, exp_rdata_i);
                end
            end
            if (irq_chk_i && (irq_i !== exp_irq_i))
            begin
                irq_err_o <= irq_err_o + 1;
                $display("ERR %0t: irq_o is %b, expected %b", $time, irq_i, exp_irq_i);
            end
        end
    end

endmodule

// ==== test/udma_cfg_stimulus.txt ====
// Columns op_a_b_data in hex. op 1 write and 2 read (a slot, b register, data expected),
// op 3 beats (a channel, b count), op 4 irq check (a cycles, b 0 from last beat, 1 from now)
1_00_00_00001000
1_00_01_00000010
1_01_00_00002000
1_01_01_0000000C
1_02_00_00003000
1_02_01_00000008
1_03_00_00004000
1_03_01_00000020
1_04_01_00000005
2_00_00_00001000
2_00_01_00000010
2_01_00_00002000
2_01_01_0000000C
2_02_00_00003000
2_02_01_00000008
2_03_00_00004000
2_03_01_00000020
2_04_01_00000005
// Beats before enable
3_00_03_00000000
2_00_03_00000000
2_00_04_00000000
4_03_01_00000000
// Channel 0 single mode
1_00_02_00000001
2_00_02_00000001
3_00_02_00000000
2_00_03_00001008
2_00_04_00000008
3_00_02_00000000
4_02_00_00000000
4_03_00_00000001
2_00_02_00000000
2_04_00_00000001
2_00_03_00001010
2_00_04_00000000
3_00_02_00000000
2_00_03_00001010
1_04_00_00000001
4_01_01_00000000
2_04_00_00000000
// Channel 2 continuous mode
1_02_02_00000003
2_02_02_00000003
3_02_01_00000000
2_02_03_00003004
3_02_01_00000000
4_02_00_00000000
4_03_00_00000001
2_02_02_00000003
2_02_03_00003000
2_02_04_00000008
2_04_00_00000004
1_04_00_00000004
4_01_01_00000000
// Channel 1 masked out, then masked in
1_01_02_00000001
3_01_03_00000000
4_03_00_00000000
2_01_02_00000000
2_04_00_00000002
1_04_01_00000007
4_01_01_00000001
1_04_00_00000002
4_01_01_00000000
// Channel 3 stopped by the clear bit
1_04_01_0000000F
1_03_02_00000001
3_03_02_00000000
2_03_03_00004008
1_03_02_00000020
2_03_02_00000000
3_03_06_00000000
2_03_03_00004008
2_03_04_00000018
4_05_00_00000000
2_04_00_00000000
0_00_00_00000000

// ==== test/udma_cfg_sva.sv ====
/* APB response and interrupt assertions, bound into the top level.
   Slots 0 to UDMA_N_CHANNELS are mapped, higher selects are never issued */

`timescale 1ns/1ns

`include "udma_cfg_settings.svh"

module udma_cfg_sva
(
    input logic                            clk_i,
    input logic                            rst_i,
    input logic [`UDMA_APB_ADDR_WIDTH-1:0] paddr_i,
    input logic                            psel_i,
    input logic                            penable_i,
    input logic                            pready_o,
    input logic                            pslverr_o,
    input logic                            irq_o
);

    // The event controller sits in the last mapped slot
    localparam logic [4:0] LAST_SLOT = 5'(`UDMA_N_CHANNELS);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    a_no_slverr: assert property (@(posedge clk_i) !pslverr_o)
    else
    begin
        $error("PSLVERR went high");
        fail_count++;
    end

    // Zero wait states on every mapped slot
    a_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        (psel_i && penable_i && (paddr_i[11:7] <= LAST_SLOT)) |-> pready_o)
    else
    begin
        $error("PREADY low in an access phase to slot %0d", paddr_i[11:7]);
        fail_count++;
    end

    a_irq_reset: assert property (@(posedge clk_i) rst_i |=> !irq_o)
    else
    begin
        $error("irq_o high while in reset");
        fail_count++;
    end

endmodule

bind udma_cfg_top udma_cfg_sva u_sva (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .irq_o     (irq_o)
);

// ==== test/udma_cfg_tb.sv ====
/* Testbench for the uDMA configuration subsystem, run from an operation file.
   Inputs change on the falling edge; the checker compares on the rising edge */

`timescale 1ns/1ns

`include "udma_cfg_settings.svh"

module udma_cfg_tb;

    import udma_cfg_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_CH       = `UDMA_N_CHANNELS;
    localparam int MAX_OPS    = 128;

    typedef logic [N_CH-1:0] beat_vec_t;

    // DUT ports
    logic                            clk_i = 1'b0;
    logic                            rst_i;
    logic [`UDMA_APB_ADDR_WIDTH-1:0] paddr_i;
    cfg_data_t                       pwdata_i;
    logic                            pwrite_i;
    logic                            psel_i;
    logic                            penable_i;
    cfg_data_t                       prdata_o;
    logic                            pready_o;
    logic                            pslverr_o;
    beat_vec_t                       beat_i;
    logic                            irq_o;

    // Expected values handed to the checker
    logic      rd_chk;
    cfg_data_t exp_rdata;
    logic      irq_chk;
    logic      exp_irq;

    // Results from the checker
    int rd_cnt;
    int rd_err;
    int irq_err;

    // Each entry is op[51:48], a[47:40], b[39:32], data[31:0]
    logic [51:0] stim_mem [0:MAX_OPS-1];
    int          n_ops;
    int          n_reads;
    int          seq_err;
    int          watchdog_cycles;
    // Rising edges seen so far, read only on falling edges
    int          cyc;
    int          last_beat_cyc;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cyc <= cyc + 1;
    end

    udma_cfg_top uut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pwrite_i  (pwrite_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .beat_i    (beat_i),
        .irq_o     (irq_o)
    );

    udma_cfg_checker u_checker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pready_i    (pready_o),
        .prdata_i    (prdata_o),
        .rd_chk_i    (rd_chk),
        .exp_rdata_i (exp_rdata),
        .irq_i       (irq_o),
        .irq_chk_i   (irq_chk),
        .exp_irq_i   (exp_irq),
        .rd_cnt_o    (rd_cnt),
        .rd_err_o    (rd_err),
        .irq_err_o   (irq_err)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Bus and beat drivers, all entered and left on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    // Setup cycle, then access cycles until the slave reports ready
    task automatic apb_access(input logic [7:0] slot, input logic [7:0] offs,
                              input logic wr, input cfg_data_t data);
        paddr_i  = {slot[4:0], offs[4:0], 2'b00};
        pwrite_i = wr;
        pwdata_i = wr ? data : '0;
        psel_i   = 1'b1;
        @(negedge clk_i);
        penable_i = 1'b1;
        // Read data is only compared for reads
        rd_chk    = ~wr;
        exp_rdata = data;
        do
            @(posedge clk_i);
        while (!pready_o);
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        rd_chk    = 1'b0;
    endtask

    // Back to back strobes on one channel
    task automatic drive_beats(input logic [7:0] chan, input logic [7:0] count);
        for (int i = 0; i < int'(count); i++)
        begin
            beat_i        = beat_vec_t'(1) << chan;
            last_beat_cyc = cyc;
            @(negedge clk_i);
        end
        beat_i = '0;
    endtask

    // Counts from the last beat's drive edge, or from now
    task automatic check_irq_level(input logic [7:0] cycles, input logic from_now,
                                   input logic level);
        int target;
        target = from_now ? cyc + int'(cycles) : last_beat_cyc + int'(cycles);
        if (cyc > target)
        begin
            $display("Irq check at %0t came %0d cycles after its slot", $time, cyc - target);
            seq_err++;
        end
        while (cyc < target)
        begin
            @(negedge clk_i);
        end
        exp_irq = level;
        irq_chk = 1'b1;
        @(negedge clk_i);
        irq_chk = 1'b0;
    endtask

    // True when an irq check timed from the last beat comes before the next beat
    function automatic logic timed_check_ahead(input int from);
        logic [3:0] next_op;
        for (int j = from; j < n_ops; j++)
        begin
            next_op = stim_mem[j][51:48];
            if (next_op == 4'h3)
            begin
                return 1'b0;
            end
            if (next_op == 4'h4 && !stim_mem[j][32])
            begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int          idx;
        int          total;
        logic [3:0]  op;
        logic [7:0]  arg_a;
        logic [7:0]  arg_b;
        cfg_data_t   data;
        rst_i         = 1'b1;
        paddr_i       = '0;
        pwdata_i      = '0;
        pwrite_i      = 1'b0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        beat_i        = '0;
        rd_chk        = 1'b0;
        exp_rdata     = '0;
        irq_chk       = 1'b0;
        exp_irq       = 1'b0;
        cyc           = 0;
        last_beat_cyc = 0;
        seq_err       = 0;
        n_ops         = 0;
        n_reads       = 0;
        void'($urandom(94887));

        for (idx = 0; idx < MAX_OPS; idx++)
        begin
            stim_mem[idx] = '0;
        end
        $readmemh("test/udma_cfg_stimulus.txt", stim_mem);
        // Op code 0 ends the list
        while (n_ops < MAX_OPS && stim_mem[n_ops][51:48] != 4'h0)
        begin
            if (stim_mem[n_ops][51:48] == 4'h2)
            begin
                n_reads++;
            end
            n_ops++;
        end
        if (n_ops == 0)
        begin
            $display("Stimulus file held no operations");
            seq_err++;
        end
        watchdog_cycles = (n_ops + 1) * 20;

        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;

        for (idx = 0; idx < n_ops; idx++)
        begin
            op    = stim_mem[idx][51:48];
            arg_a = stim_mem[idx][47:40];
            arg_b = stim_mem[idx][39:32];
            data  = stim_mem[idx][31:0];
            // Ops between the beats and an irq check timed from them run back to back
            if (op != 4'h4 && !timed_check_ahead(idx))
            begin
                repeat ($urandom % 3) @(negedge clk_i);
            end
            case (op)
                4'h1: apb_access(arg_a, arg_b, 1'b1, data);
                4'h2: apb_access(arg_a, arg_b, 1'b0, data);
                4'h3: drive_beats(arg_a, arg_b);
                4'h4: check_irq_level(arg_a, arg_b[0], data[0]);
                default:
                begin
                    $display("Unknown operation code %0h in stimulus entry %0d", op, idx);
                    seq_err++;
                end
            endcase
        end

        repeat (4) @(negedge clk_i);
        if (rd_cnt != n_reads)
        begin
            $display("Checker saw %0d completed reads but the stimulus has %0d",
                     rd_cnt, n_reads);
            seq_err++;
        end
        total = rd_err + irq_err + uut.u_sva.fail_count + seq_err;
        $display("Reads checked %0d, read errors %0d, irq errors %0d, assertion failures %0d, %s %0d",
                 rd_cnt, rd_err, irq_err, uut.u_sva.fail_count, "sequence errors", seq_err);
        if (total == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from the operation count
    initial
    begin
        wait (watchdog_cycles > 0);
        #(watchdog_cycles * CLK_PERIOD);
        $display("Timeout after %0d cycles, the stimulus did not finish", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule
